//--- Makefile
VERILATOR  := verilator
TOP        := tb_ml_demodulator
RTL_TOP    := ml_demodulator
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Test failed
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+rtl
rtl/ml_data_pkg.sv
rtl/ml_ctrl_pkg.sv
rtl/ml_input_regs.sv
rtl/ml_search_ctrl.sv
rtl/ml_metric_unit.sv
rtl/ml_bit_min_tracker.sv
rtl/ml_llr_buffer.sv
rtl/ml_demodulator.sv
sim/tb_clock_gen.sv
sim/tb_ml_demodulator.sv

//--- rtl/ml_bit_min_tracker.sv
`include "ml_demod_cfg.svh"

module ml_bit_min_tracker (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_clear,
    input  logic                    i_step,
    input  logic                    i_last,
    input  ml_data_pkg::cand_base_t i_cand_base,
    input  ml_data_pkg::metric_t    i_metric [`ML_CANDS_PER_CYCLE],
    output ml_data_pkg::llr_vec_t   o_llr_vec,
    output logic                    o_llr_wr
);

    localparam int NB     = `ML_NUM_BITS;
    localparam int LANES  = `ML_CANDS_PER_CYCLE;
    localparam int LANE_W = $clog2(LANES);

    ml_data_pkg::metric_t min0 [NB];      // best metric with bit = 0
    ml_data_pkg::metric_t min1 [NB];      // best metric with bit = 1
    ml_data_pkg::metric_t min0_nxt [NB];
    ml_data_pkg::metric_t min1_nxt [NB];

    // lanes folded in order, lane 0 first
    always_comb begin
        ml_data_pkg::cand_idx_t cand;
        min0_nxt = min0;
        min1_nxt = min1;
        for (int l = 0; l < LANES; l++) begin
            cand = {i_cand_base, LANE_W'(l)};
            for (int b = 0; b < NB; b++) begin
                if (cand[b]) begin
                    if (i_metric[l] < min1_nxt[b]) begin
                        min1_nxt[b] = i_metric[l];
                    end
                end else if (i_metric[l] < min0_nxt[b]) begin
                    min0_nxt[b] = i_metric[l];
                end
            end
        end
    end

    // llr from the minima including the group of this cycle
    always_comb begin
        ml_data_pkg::metric_t diff;
        ml_data_pkg::llr_t    llr;
        for (int b = 0; b < NB; b++) begin
            diff = min1_nxt[b] - min0_nxt[b];
            llr  = ml_data_pkg::llr_t'(diff >>> `ML_LLR_SHIFT);
            if (llr == '0) begin
                llr = ml_data_pkg::llr_t'(1);  // zero would give no hard decision
            end
            o_llr_vec[b] = llr;
        end
    end

    assign o_llr_wr = i_step && i_last;  // buffer stores at the edge closing the search

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            for (int b = 0; b < NB; b++) begin
                min0[b] <= ml_data_pkg::METRIC_MAX;
                min1[b] <= ml_data_pkg::METRIC_MAX;
            end
        end else if (i_clear) begin
            for (int b = 0; b < NB; b++) begin
                min0[b] <= ml_data_pkg::METRIC_MAX;
                min1[b] <= ml_data_pkg::METRIC_MAX;
            end
        end else if (i_step) begin
            min0 <= min0_nxt;
            min1 <= min1_nxt;
        end
    end

endmodule

//--- rtl/ml_ctrl_pkg.sv
package ml_ctrl_pkg;

    // search engine state
    typedef enum logic {
        ST_IDLE,
        ST_SEARCH
    } search_state_t;

endpackage

//--- rtl/ml_data_pkg.sv
`include "ml_demod_cfg.svh"

package ml_data_pkg;

    // one real or imaginary part of y or R
    typedef logic signed [`ML_SAMPLE_W-1:0] sample_t;

    // squared distance of one candidate
    typedef logic signed [`ML_METRIC_W-1:0] metric_t;

    // start value of every running minimum
    localparam metric_t METRIC_MAX = {1'b0, {(`ML_METRIC_W-1){1'b1}}};

    typedef logic signed [`ML_LLR_W-1:0] llr_t;

    // full candidate index, two sign bits per stream
    typedef logic [`ML_NUM_BITS-1:0] cand_idx_t;

    // group of candidates handled in one cycle
    typedef logic [$clog2(`ML_SEARCH_CYCLES)-1:0] cand_base_t;

    // slot b holds the llr of bit b
    typedef llr_t [`ML_NUM_BITS-1:0] llr_vec_t;

endpackage

//--- rtl/ml_demod_cfg.svh
`ifndef ML_DEMOD_CFG_SVH
`define ML_DEMOD_CFG_SVH

// received vector and channel matrix format
`define ML_SAMPLE_W         20
`define ML_NUM_STREAMS      4

// candidate search
`define ML_NUM_BITS         8
`define ML_CANDS_PER_CYCLE  4
`define ML_SEARCH_CYCLES    64

// metric datapath widths
`define ML_ROWSUM_W         23
`define ML_SCALE_SQRT2      181   // sqrt2 in 1.7 format
`define ML_DIFF_W           24
`define ML_SQ_IN_W          13
`define ML_METRIC_W         28

// soft output
`define ML_LLR_W            8
`define ML_LLR_SHIFT        6
`define ML_BUF_FRAMES       4

`endif

//--- rtl/ml_demodulator.sv
`include "ml_demod_cfg.svh"

module ml_demodulator (
    input  logic                                                 i_clk,
    input  logic                                                 i_reset,
    input  logic                                                 i_trig,
    input  logic [2*`ML_NUM_STREAMS*`ML_SAMPLE_W-1:0]             i_y_hat,
    input  logic [`ML_NUM_STREAMS*`ML_NUM_STREAMS*`ML_SAMPLE_W-1:0] i_r,
    input  logic                                                 i_rd_rdy,
    output logic                                                 o_rd_vld,
    output ml_data_pkg::llr_t                                    o_llr,
    output logic                                                 o_hard_bit
);

    localparam int NS     = `ML_NUM_STREAMS;
    localparam int LANES  = `ML_CANDS_PER_CYCLE;
    localparam int LANE_W = $clog2(LANES);

    ml_data_pkg::sample_t    y_reg [2*NS];
    ml_data_pkg::sample_t    r_reg [NS*NS];
    ml_data_pkg::cand_base_t cand_base;
    ml_data_pkg::metric_t    metric [LANES];
    ml_data_pkg::llr_vec_t   llr_vec;
    logic                    load;
    logic                    step;
    logic                    last;
    logic                    has_room;
    logic                    llr_wr;

    ml_input_regs u_input_regs (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_load  (load),
        .i_y_hat (i_y_hat),
        .i_r     (i_r),
        .o_y     (y_reg),
        .o_r     (r_reg)
    );

    ml_search_ctrl u_search_ctrl (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_trig      (i_trig),
        .i_has_room  (has_room),
        .o_load      (load),
        .o_cand_base (cand_base),
        .o_step      (step),
        .o_last      (last)
    );

    // one metric unit per lane, lane number fills the low index bits
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        ml_metric_unit u_metric (
            .i_y      (y_reg),
            .i_r      (r_reg),
            .i_cand   ({cand_base, LANE_W'(l)}),
            .o_metric (metric[l])
        );
    end

    ml_bit_min_tracker u_min_tracker (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_clear     (load),
        .i_step      (step),
        .i_last      (last),
        .i_cand_base (cand_base),
        .i_metric    (metric),
        .o_llr_vec   (llr_vec),
        .o_llr_wr    (llr_wr)
    );

    ml_llr_buffer u_llr_buffer (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wr       (llr_wr),
        .i_llr_vec  (llr_vec),
        .i_rd_rdy   (i_rd_rdy),
        .o_rd_vld   (o_rd_vld),
        .o_llr      (o_llr),
        .o_has_room (has_room)
    );

    assign o_hard_bit = o_llr[`ML_LLR_W-1];  // negative llr means bit 1

endmodule

//--- rtl/ml_input_regs.sv
`include "ml_demod_cfg.svh"

module ml_input_regs (
    input  logic                                                 i_clk,
    input  logic                                                 i_reset,
    input  logic                                                 i_load,
    input  logic [2*`ML_NUM_STREAMS*`ML_SAMPLE_W-1:0]             i_y_hat,
    input  logic [`ML_NUM_STREAMS*`ML_NUM_STREAMS*`ML_SAMPLE_W-1:0] i_r,
    output ml_data_pkg::sample_t                                 o_y [2*`ML_NUM_STREAMS],
    output ml_data_pkg::sample_t                                 o_r [`ML_NUM_STREAMS*`ML_NUM_STREAMS]
);

    localparam int NUM_Y = 2 * `ML_NUM_STREAMS;               // re/im per stream
    localparam int NUM_R = `ML_NUM_STREAMS * `ML_NUM_STREAMS; // upper triangle, real diagonal
    localparam int W     = `ML_SAMPLE_W;

    // held for the whole search, only a load can change them
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            for (int k = 0; k < NUM_Y; k++) begin
                o_y[k] <= '0;
            end
            for (int k = 0; k < NUM_R; k++) begin
                o_r[k] <= '0;
            end
        end else if (i_load) begin
            for (int k = 0; k < NUM_Y; k++) begin
                o_y[k] <= i_y_hat[k*W +: W];  // stream k/2, re then im
            end
            // column order r11, r12, r22, r13, r23, r33, ...
            for (int k = 0; k < NUM_R; k++) begin
                o_r[k] <= i_r[k*W +: W];
            end
        end
    end

endmodule

//--- rtl/ml_llr_buffer.sv
`include "ml_demod_cfg.svh"

module ml_llr_buffer (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_wr,
    input  ml_data_pkg::llr_vec_t i_llr_vec,
    input  logic                  i_rd_rdy,
    output logic                  o_rd_vld,
    output ml_data_pkg::llr_t     o_llr,
    output logic                  o_has_room
);

    localparam int FRAMES = `ML_BUF_FRAMES;
    localparam int SLOT_W = $clog2(`ML_NUM_BITS);
    localparam int FR_W   = $clog2(FRAMES);
    localparam int RD_W   = FR_W + SLOT_W;
    localparam int CNT_W  = $clog2(FRAMES + 1);

    ml_data_pkg::llr_vec_t frames [FRAMES];
    logic [FR_W-1:0]       wr_ptr;      // next frame slot to fill
    logic [RD_W-1:0]       rd_ptr;      // frame in upper bits, llr slot in lower bits
    logic [CNT_W-1:0]      count;       // frames not yet fully read
    logic                  rd_fire;
    logic                  frame_done;

    assign o_rd_vld   = (count != '0);
    assign o_has_room = (count < CNT_W'(FRAMES));
    assign o_llr      = frames[rd_ptr[RD_W-1:SLOT_W]][rd_ptr[SLOT_W-1:0]];
    assign rd_fire    = o_rd_vld && i_rd_rdy;
    assign frame_done = rd_fire && (rd_ptr[SLOT_W-1:0] == SLOT_W'(`ML_NUM_BITS - 1));

    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            frames[wr_ptr] <= i_llr_vec;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= (wr_ptr == FR_W'(FRAMES - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == RD_W'(FRAMES * `ML_NUM_BITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(i_wr) - CNT_W'(frame_done);
        end
    end

endmodule

//--- rtl/ml_metric_unit.sv
`include "ml_demod_cfg.svh"

module ml_metric_unit (
    input  ml_data_pkg::sample_t   i_y [2*`ML_NUM_STREAMS],
    input  ml_data_pkg::sample_t   i_r [`ML_NUM_STREAMS*`ML_NUM_STREAMS],
    input  ml_data_pkg::cand_idx_t i_cand,
    output ml_data_pkg::metric_t   o_metric
);

    localparam int NS      = `ML_NUM_STREAMS;
    localparam int ROW_LSB = 8;   // fraction bits dropped before the sqrt2 scale

    localparam logic signed [8:0] SQRT2 = 9'(`ML_SCALE_SQRT2);

    typedef logic signed [`ML_ROWSUM_W-1:0] rowsum_t;

    // sign of one qpsk component applied to a matrix entry, wraps at 20 bits
    function automatic ml_data_pkg::sample_t signed_term(ml_data_pkg::sample_t v, logic neg);
        return neg ? -v : v;
    endfunction

    // one squared component of |y - sqrt2 * R s|
    function automatic ml_data_pkg::metric_t dist_sq(ml_data_pkg::sample_t y, rowsum_t rs);
        rowsum_t                        scaled;
        logic signed [`ML_DIFF_W-1:0]   diff;
        logic signed [`ML_SQ_IN_W-1:0]  top;
        scaled = $signed(rs[`ML_ROWSUM_W-1:ROW_LSB]) * SQRT2;  // low 23 bits kept
        diff   = y - scaled;
        top    = diff[`ML_DIFF_W-1 -: `ML_SQ_IN_W];
        return top * top;
    endfunction

    // entry (i,j) of column j sits at j*j + 2i (re) and j*j + 2i + 1 (im)
    // diagonal entry of column j sits at j*j + 2j
    always_comb begin
        rowsum_t              row_re;
        rowsum_t              row_im;
        ml_data_pkg::metric_t acc;
        acc = '0;
        for (int i = 0; i < NS; i++) begin
            row_re = '0;
            row_im = '0;
            for (int j = i; j < NS; j++) begin
                if (j == i) begin
                    row_re += signed_term(i_r[j*j+2*j], i_cand[2*j]);
                    row_im += signed_term(i_r[j*j+2*j], i_cand[2*j+1]);
                end else begin
                    // (a + jb)(sr + j si) with sr, si = +-1
                    row_re += signed_term(i_r[j*j+2*i], i_cand[2*j])
                            + signed_term(i_r[j*j+2*i+1], !i_cand[2*j+1]);
                    row_im += signed_term(i_r[j*j+2*i], i_cand[2*j+1])
                            + signed_term(i_r[j*j+2*i+1], i_cand[2*j]);
                end
            end
            acc += dist_sq(i_y[2*i], row_re);
            acc += dist_sq(i_y[2*i+1], row_im);
        end
        o_metric = acc;
    end

endmodule

//--- rtl/ml_search_ctrl.sv
`include "ml_demod_cfg.svh"

module ml_search_ctrl (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_trig,
    input  logic                    i_has_room,
    output logic                    o_load,
    output ml_data_pkg::cand_base_t o_cand_base,
    output logic                    o_step,
    output logic                    o_last
);

    localparam ml_data_pkg::cand_base_t LAST_GROUP =
        ml_data_pkg::cand_base_t'(`ML_SEARCH_CYCLES - 1);

    ml_ctrl_pkg::search_state_t state;
    ml_data_pkg::cand_base_t    cnt;     // current candidate group

    // trigger only counts when idle and a result slot is free
    assign o_load      = (state == ml_ctrl_pkg::ST_IDLE) && i_trig && i_has_room;
    assign o_step      = (state == ml_ctrl_pkg::ST_SEARCH);
    assign o_last      = o_step && (cnt == LAST_GROUP);
    assign o_cand_base = cnt;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state <= ml_ctrl_pkg::ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ml_ctrl_pkg::ST_IDLE: begin
                    if (o_load) begin
                        state <= ml_ctrl_pkg::ST_SEARCH;
                        cnt   <= '0;
                    end
                end
                ml_ctrl_pkg::ST_SEARCH: begin
                    cnt <= cnt + 1'b1;
                    if (o_last) begin
                        state <= ml_ctrl_pkg::ST_IDLE;  // frame goes out on this edge
                    end
                end
                default: state <= ml_ctrl_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // release on a falling edge, away from the drive and sample points
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule

//--- sim/tb_ml_demodulator.sv
`include "ml_demod_cfg.svh"

module tb_ml_demodulator;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NS         = `ML_NUM_STREAMS;
    localparam int NB         = `ML_NUM_BITS;
    localparam int W          = `ML_SAMPLE_W;
    localparam int WAIT_LIMIT = 200;
    localparam int IDENT_DIAG = 1 << 16;
    localparam int IDENT_AMP  = (IDENT_DIAG >> 8) * `ML_SCALE_SQRT2;  // noiseless qpsk level

    logic               clk;
    logic               reset;
    logic               trig;
    logic               rd_rdy;
    logic [2*NS*W-1:0]  y_hat;
    logic [NS*NS*W-1:0] r_bus;
    logic               rd_vld;
    ml_data_pkg::llr_t  llr_out;
    logic               hard_bit;

    ml_data_pkg::sample_t y_vec [2*NS];
    ml_data_pkg::sample_t r_re [NS][NS];
    ml_data_pkg::sample_t r_im [NS][NS];   // diagonal stays zero
    ml_data_pkg::llr_t    exp_q [$];       // model llrs in read order
    logic                 hard_seen [$];
    integer               seed;
    int                   llr_errors;
    int                   hard_errors;
    int                   flow_errors;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clock_gen (.o_clk(clk), .o_reset(reset));

    ml_demodulator i_dut (
        .i_clk      (clk),
        .i_reset    (reset),
        .i_trig     (trig),
        .i_y_hat    (y_hat),
        .i_r        (r_bus),
        .i_rd_rdy   (rd_rdy),
        .o_rd_vld   (rd_vld),
        .o_llr      (llr_out),
        .o_hard_bit (hard_bit)
    );

    task automatic tick();
        @(posedge clk);
        #2;  // drive and sample point
    endtask

    task automatic wait_cycles(int n);
        for (int k = 0; k < n; k++) begin
            tick();
        end
    endtask

    function automatic longint wrap_to(longint v, int w);
        longint t;
        t = v <<< (64 - w);
        return t >>> (64 - w);
    endfunction

    // one squared component, truncations as in the metric rule
    function automatic longint dist_part(ml_data_pkg::sample_t y, longint row_sum);
        longint rs;
        longint prod;
        longint diff;
        longint top;
        rs   = wrap_to(row_sum, `ML_ROWSUM_W);
        prod = wrap_to((rs >>> 8) * `ML_SCALE_SQRT2, `ML_ROWSUM_W);
        diff = wrap_to(longint'(y) - prod, `ML_DIFF_W);
        top  = diff >>> (`ML_DIFF_W - `ML_SQ_IN_W);
        return top * top;
    endfunction

    function automatic longint cand_metric(int cand);
        longint sr [NS];
        longint si [NS];
        longint rs_re;
        longint rs_im;
        longint acc;
        for (int s = 0; s < NS; s++) begin
            sr[s] = cand[2*s] ? -64'sd1 : 64'sd1;
            si[s] = cand[2*s+1] ? -64'sd1 : 64'sd1;
        end
        acc = 0;
        for (int i = 0; i < NS; i++) begin
            rs_re = longint'(r_re[i][i]) * sr[i];
            rs_im = longint'(r_re[i][i]) * si[i];
            for (int j = i + 1; j < NS; j++) begin
                rs_re += longint'(r_re[i][j]) * sr[j] - longint'(r_im[i][j]) * si[j];
                rs_im += longint'(r_re[i][j]) * si[j] + longint'(r_im[i][j]) * sr[j];
            end
            acc += dist_part(y_vec[2*i], rs_re) + dist_part(y_vec[2*i+1], rs_im);
        end
        return wrap_to(acc, `ML_METRIC_W);
    endfunction

    // full search over all candidates, then the llr rule per bit
    task automatic push_expected();
        longint min0 [NB];
        longint min1 [NB];
        longint m;
        longint v;
        for (int b = 0; b < NB; b++) begin
            min0[b] = (64'sd1 <<< (`ML_METRIC_W - 1)) - 1;
            min1[b] = min0[b];
        end
        for (int c = 0; c < (1 << NB); c++) begin
            m = cand_metric(c);
            for (int b = 0; b < NB; b++) begin
                if (c[b] && m < min1[b]) min1[b] = m;
                if (!c[b] && m < min0[b]) min0[b] = m;
            end
        end
        for (int b = 0; b < NB; b++) begin
            v = wrap_to((min1[b] - min0[b]) >>> `ML_LLR_SHIFT, `ML_LLR_W);
            if (v == 0) v = 1;
            exp_q.push_back(ml_data_pkg::llr_t'(v));
        end
    endtask

    task automatic randomize_inputs();
        for (int k = 0; k < 2*NS; k++) begin
            y_vec[k] = ml_data_pkg::sample_t'($random(seed) >>> 14);  // about +-2^17
        end
        for (int i = 0; i < NS; i++) begin
            for (int j = 0; j < NS; j++) begin
                r_re[i][j] = (j >= i) ? ml_data_pkg::sample_t'($random(seed) >>> 15) : '0;
                r_im[i][j] = (j > i) ? ml_data_pkg::sample_t'($random(seed) >>> 15) : '0;
            end
        end
    endtask

    // bus order r11, r12 re/im, r22, r13 re/im, r23 re/im, r33, ...
    task automatic fire_trigger();
        int k;
        for (int n = 0; n < 2*NS; n++) begin
            y_hat[n*W +: W] = y_vec[n];
        end
        k = 0;
        for (int j = 0; j < NS; j++) begin
            for (int i = 0; i < j; i++) begin
                r_bus[k*W +: W]     = r_re[i][j];
                r_bus[(k+1)*W +: W] = r_im[i][j];
                k += 2;
            end
            r_bus[k*W +: W] = r_re[j][j];
            k++;
        end
        trig = 1'b1;
        tick();
        trig = 1'b0;
    endtask

    task automatic check_llr(ml_data_pkg::llr_t got, ml_data_pkg::llr_t exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s llr %0d, expected %0d", $time, what, got, exp);
            llr_errors++;
        end
    endtask

    task automatic check_hard_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s hard bit %b, expected %b", $time, what, got, exp);
            hard_errors++;
        end
    endtask

    task automatic wait_rd_vld(output bit ok, input string what);
        int n;
        n = 0;
        while (rd_vld !== 1'b1 && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        ok = (rd_vld === 1'b1);
        if (!ok) begin
            $display("timeout in %s: no LLR became readable within %0d cycles", what, WAIT_LIMIT);
            flow_errors++;
        end
    endtask

    task automatic read_llrs(int n, string what);
        bit                ok;
        ml_data_pkg::llr_t exp;
        hard_seen.delete();
        rd_rdy = 1'b1;
        for (int k = 0; k < n; k++) begin
            wait_rd_vld(ok, what);
            if (!ok) break;
            hard_seen.push_back(hard_bit);
            if (exp_q.size() == 0) begin
                $display("%s returned more LLRs than the model predicted", what);
                flow_errors++;
            end else begin
                exp = exp_q.pop_front();
                check_llr(llr_out, exp, $sformatf("%s #%0d", what, k));
                check_hard_bit(hard_bit, exp[`ML_LLR_W-1], $sformatf("%s #%0d", what, k));
            end
            tick();  // this edge consumes the entry
        end
        rd_rdy = 1'b0;
    endtask

    // nothing may be left to read, now or for the next n cycles
    task automatic expect_drained(int n, string what);
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected LLRs were never read", what, exp_q.size());
            flow_errors++;
            exp_q.delete();
        end
        for (int k = 0; k <= n; k++) begin
            if (rd_vld !== 1'b0) begin
                $display("%s: o_rd_vld is high although no frame should be buffered", what);
                flow_errors++;
                break;
            end
            if (k < n) tick();
        end
    endtask

    task automatic test_idle_after_reset();
        expect_drained(10, "idle after reset");
    endtask

    task automatic test_identity();
        logic [NB-1:0] tx;
        tx = 8'hb4;
        for (int i = 0; i < NS; i++) begin
            for (int j = 0; j < NS; j++) begin
                r_re[i][j] = (i == j) ? ml_data_pkg::sample_t'(IDENT_DIAG) : '0;
                r_im[i][j] = '0;
            end
        end
        for (int k = 0; k < 2*NS; k++) begin
            y_vec[k] = ml_data_pkg::sample_t'(tx[k] ? -IDENT_AMP : IDENT_AMP);
        end
        push_expected();
        fire_trigger();
        read_llrs(NB, "identity");
        for (int b = 0; b < NB && b < hard_seen.size(); b++) begin
            check_hard_bit(hard_seen[b], tx[b], $sformatf("identity tx bit %0d", b));
        end
        expect_drained(2, "identity");
    endtask

    task automatic test_random();
        randomize_inputs();
        push_expected();
        fire_trigger();
        read_llrs(NB, "random");
        expect_drained(2, "random");
    endtask

    task automatic test_latency();
        int cyc;
        randomize_inputs();
        push_expected();
        fire_trigger();          // now one drive point past the accept edge
        cyc = 1;
        while (rd_vld !== 1'b1 && cyc < WAIT_LIMIT) begin
            tick();
            cyc++;
        end
        if (rd_vld !== 1'b1) begin
            $display("timeout in latency: o_rd_vld never rose after the trigger");
            flow_errors++;
        end else if (cyc != `ML_SEARCH_CYCLES + 1) begin
            $display("FAILED at %0t: o_rd_vld rose in cycle %0d, expected %0d",
                     $time, cyc, `ML_SEARCH_CYCLES + 1);
            flow_errors++;
        end
        read_llrs(NB, "latency");
        expect_drained(2, "latency");
    endtask

    task automatic test_backpressure();
        for (int f = 0; f < `ML_BUF_FRAMES; f++) begin
            randomize_inputs();
            push_expected();
            fire_trigger();
            wait_cycles(`ML_SEARCH_CYCLES + 2);
        end
        randomize_inputs();      // buffer is full, this one is dropped
        fire_trigger();
        wait_cycles(`ML_SEARCH_CYCLES + 2);
        read_llrs(`ML_BUF_FRAMES * NB, "backpressure");
        expect_drained(2, "backpressure");
    endtask

    task automatic test_trig_during_search();
        randomize_inputs();
        push_expected();
        fire_trigger();
        wait_cycles(10);
        randomize_inputs();      // engine busy, must not load
        fire_trigger();
        read_llrs(NB, "busy trigger");
        expect_drained(`ML_SEARCH_CYCLES + 2, "busy trigger");
    endtask

    initial begin
        int n;
        seed        = 32'h674f4f99;
        trig        = 1'b0;
        rd_rdy      = 1'b0;
        y_hat       = '0;
        r_bus       = '0;
        llr_errors  = 0;
        hard_errors = 0;
        flow_errors = 0;
        n = 0;
        while (reset !== 1'b0 && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (reset !== 1'b0) begin
            $display("reset was never released");
            flow_errors++;
        end
        test_idle_after_reset();
        test_identity();
        test_random();
        test_latency();
        test_backpressure();
        test_trig_during_search();
        $display("errors: llr %0d, hard bit %0d, flow %0d", llr_errors, hard_errors, flow_errors);
        if (llr_errors + hard_errors + flow_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
